// ==== digit_multiplier.sv ====
`timescale 1ns/10ps

module digit_multiplier (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  fp_pkg::mantissa_t a,
    input  fp_pkg::mantissa_t b,
    output fp_pkg::product_t  p,
    output logic              done
);
    import fp_pkg::*;

    typedef logic [$clog2(MUL_DIGITS)-1:0]   col_t;
    typedef logic [$clog2(MUL_DIGITS+1)-1:0] row_t;

    col_t                    a_pos;
    row_t                    b_pos;
    mantissa_t               a_digits;
    mantissa_t               b_digits;
    logic [2*DIGIT_BITS-1:0] partial;
    product_t                shifted;
    product_t                acc;

    // Product of the lowest digits moves up to digit position a_pos + b_pos.
    assign partial = a_digits[DIGIT_BITS-1:0] * b_digits[DIGIT_BITS-1:0];
    assign shifted = product_t'(partial) << ((a_pos + b_pos) * DIGIT_BITS);

    assign done = (b_pos == row_t'(MUL_DIGITS));
    assign p    = acc;

    always_ff @(posedge clk) begin
        if (rst) begin
            a_pos <= '0;
            b_pos <= row_t'(MUL_DIGITS);
        end else if (start) begin
            a_pos <= '0;
            b_pos <= '0;
        end else if (!done) begin
            if (a_pos == col_t'(MUL_DIGITS - 1)) begin
                a_pos <= '0;
                b_pos <= b_pos + 1'b1;
            end else begin
                a_pos <= a_pos + 1'b1;
            end
        end
    end

    // One partial product per cycle.
    always_ff @(posedge clk) begin
        if (start) begin
            a_digits <= a;
            b_digits <= b;
            acc      <= '0;
        end else if (!done) begin
            a_digits <= {a_digits[DIGIT_BITS-1:0], a_digits[MANT_BITS-1:DIGIT_BITS]};
            if (a_pos == col_t'(MUL_DIGITS - 1)) begin
                b_digits <= {b_digits[DIGIT_BITS-1:0], b_digits[MANT_BITS-1:DIGIT_BITS]};
            end
            acc <= acc + shifted;
        end
    end

endmodule

// ==== fp_adder.sv ====
`timescale 1ns/10ps

module fp_adder (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  fp_pkg::float_t a,
    input  fp_pkg::float_t b,
    output fp_pkg::float_t sum,
    output logic           done
);
    import fp_pkg::*;

    add_state_t                  state;
    fp_fields_t                  a_r;
    fp_fields_t                  b_r;
    mantissa_t                   mant_a;
    mantissa_t                   mant_b;
    logic signed [MANT_BITS+1:0] op_a;
    logic signed [MANT_BITS+1:0] op_b;
    logic signed [MANT_BITS+1:0] total;
    logic [MANT_BITS:0]          mag;
    exponent_t                   exp_r;
    logic                        sum_sign;
    logic                        sign_r;

    assign mant_a = (a_r.exp == '0) ? '0 : {1'b1, a_r.frac};
    assign mant_b = (b_r.exp == '0) ? '0 : {1'b1, b_r.frac};
    assign total  = op_a + op_b;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ADD_IDLE;
        end else begin
            case (state)
                ADD_IDLE: begin
                    if (start) begin
                        a_r   <= a;
                        b_r   <= b;
                        state <= ADD_ALIGN;
                    end
                end
                ////////////////////////////////////////
                // Shift the smaller operand right.
                ////////////////////////////////////////
                ADD_ALIGN: begin
                    if (a_r.exp > b_r.exp) begin
                        op_a  <= {2'b00, mant_a};
                        op_b  <= {2'b00, mant_b >> (a_r.exp - b_r.exp)};
                        exp_r <= a_r.exp;
                    end else begin
                        op_a  <= {2'b00, mant_a >> (b_r.exp - a_r.exp)};
                        op_b  <= {2'b00, mant_b};
                        exp_r <= b_r.exp;
                    end
                    state <= ADD_SIGN;
                end
                ADD_SIGN: begin
                    if (a_r.sign == b_r.sign) begin
                        sum_sign <= a_r.sign;
                    end else begin
                        // With mixed signs the sum itself carries the sign.
                        sum_sign <= 1'b0;
                        if (a_r.sign) begin
                            op_a <= -op_a;
                        end else begin
                            op_b <= -op_b;
                        end
                    end
                    state <= ADD_SUM;
                end
                ADD_SUM: begin
                    if (total[MANT_BITS+1]) begin
                        sign_r <= 1'b1;
                        mag    <= -total[MANT_BITS:0];
                    end else begin
                        sign_r <= sum_sign;
                        mag    <= total[MANT_BITS:0];
                    end
                    state <= ADD_NORM;
                end
                ////////////////////////////////////////
                // Put the leading one at the hidden bit.
                ////////////////////////////////////////
                default: begin
                    if (mag[MANT_BITS]) begin
                        mag   <= mag >> 1;
                        exp_r <= exp_r + 1'b1;
                        state <= ADD_IDLE;
                    end else if (!mag[MANT_BITS-1]) begin
                        if (mag == '0) begin
                            sign_r <= 1'b0;
                            exp_r  <= '0;
                            state  <= ADD_IDLE;
                        end else begin
                            mag   <= mag << 1;
                            exp_r <= exp_r - 1'b1;
                        end
                    end else begin
                        state <= ADD_IDLE;
                    end
                end
            endcase
        end
    end

    assign sum  = fp_fields_t'{sign: sign_r, exp: exp_r, frac: mag[FRAC_BITS-1:0]};
    assign done = (state == ADD_IDLE);

endmodule

// ==== fp_multiplier.sv ====
`timescale 1ns/10ps

module fp_multiplier (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  fp_pkg::float_t a,
    input  fp_pkg::float_t b,
    output fp_pkg::float_t product,
    output logic           done
);
    import fp_pkg::*;

    mul_state_t           state;
    fp_fields_t           a_r;
    fp_fields_t           b_r;
    logic                 sign_r;
    exponent_t            exp_r;
    logic [FRAC_BITS-1:0] frac_r;
    mantissa_t            mant_a;
    mantissa_t            mant_b;
    product_t             mant_p;
    logic                 mant_start;
    logic                 mant_done;

    // Zero exponent flushes the operand to zero.
    assign mant_a = (a_r.exp == '0) ? '0 : {1'b1, a_r.frac};
    assign mant_b = (b_r.exp == '0) ? '0 : {1'b1, b_r.frac};

    assign mant_start = (state == MUL_START);

    digit_multiplier i_digits (
        .clk   (clk),
        .rst   (rst),
        .start (mant_start),
        .a     (mant_a),
        .b     (mant_b),
        .p     (mant_p),
        .done  (mant_done)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= MUL_IDLE;
        end else begin
            case (state)
                MUL_IDLE: begin
                    if (start) begin
                        a_r   <= a;
                        b_r   <= b;
                        state <= MUL_START;
                    end
                end
                MUL_START: begin
                    sign_r <= a_r.sign ^ b_r.sign;
                    // Product has two integer bits, so start one above.
                    exp_r  <= a_r.exp + b_r.exp - exponent_t'(EXP_BIAS) + 1'b1;
                    state  <= MUL_WAIT;
                end
                MUL_WAIT: begin
                    if (mant_done) begin
                        state <= MUL_NORM;
                    end
                end
                default: begin
                    if (mant_p == '0) begin
                        sign_r <= 1'b0;
                        exp_r  <= '0;
                        frac_r <= '0;
                    end else if (mant_p[PROD_BITS-1]) begin
                        frac_r <= mant_p[PROD_BITS-2 -: FRAC_BITS];
                    end else begin
                        frac_r <= mant_p[PROD_BITS-3 -: FRAC_BITS];
                        exp_r  <= exp_r - 1'b1;
                    end
                    state <= MUL_IDLE;
                end
            endcase
        end
    end

    assign product = fp_fields_t'{sign: sign_r, exp: exp_r, frac: frac_r};
    assign done    = (state == MUL_IDLE);

endmodule

// ==== fp_pkg.sv ====
package fp_pkg;

    ////////////////////////////////////////
    // Binary32 format.
    ////////////////////////////////////////

    localparam int EXP_BITS   = 8;
    localparam int FRAC_BITS  = 23;
    localparam int EXP_BIAS   = 127;
    localparam int FLOAT_BITS = 1 + EXP_BITS + FRAC_BITS;
    localparam int MANT_BITS  = FRAC_BITS + 1;
    localparam int PROD_BITS  = 2 * MANT_BITS;

    // Digit-serial multiplier shape.
    localparam int DIGIT_BITS = 12;
    localparam int MUL_DIGITS = 2;

    typedef logic [FLOAT_BITS-1:0] float_t;
    typedef logic [EXP_BITS-1:0]   exponent_t;
    typedef logic [MANT_BITS-1:0]  mantissa_t;
    typedef logic [PROD_BITS-1:0]  product_t;

    typedef struct packed {
        logic                 sign;
        exponent_t            exp;
        logic [FRAC_BITS-1:0] frac;
    } fp_fields_t;

    typedef enum logic [1:0] {
        OP_ADD,
        OP_SUB,
        OP_MUL,
        OP_ITOF
    } fp_op_t;

    typedef struct packed {
        fp_op_t op;
        float_t a;
        float_t b;
    } fp_request_t;

    ////////////////////////////////////////
    // State machines.
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        ADD_IDLE,
        ADD_ALIGN,
        ADD_SIGN,
        ADD_SUM,
        ADD_NORM
    } add_state_t;

    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_START,
        MUL_WAIT,
        MUL_NORM
    } mul_state_t;

endpackage

// ==== fp_unit.sv ====
`timescale 1ns/10ps

module fp_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  fp_pkg::fp_request_t req,
    output fp_pkg::float_t      result,
    output logic                ready
);
    import fp_pkg::*;

    fp_request_t req_r;
    logic        busy;
    logic        accept;
    logic        finish;
    logic        add_start;
    logic        mul_start;
    logic        add_done;
    logic        mul_done;
    fp_fields_t  b_fields;
    float_t      add_b;
    float_t      add_sum;
    float_t      mul_product;
    float_t      itof_f;
    logic        unit_done;
    float_t      unit_result;

    assign accept = start && !busy;
    assign ready  = !busy;

    // Subtraction reuses the adder with b negated.
    always_comb begin
        b_fields = req_r.b;
        if (req_r.op == OP_SUB) begin
            b_fields.sign = ~b_fields.sign;
        end
    end
    assign add_b = b_fields;

    fp_adder i_adder (
        .clk   (clk),
        .rst   (rst),
        .start (add_start),
        .a     (req_r.a),
        .b     (add_b),
        .sum   (add_sum),
        .done  (add_done)
    );

    fp_multiplier i_multiplier (
        .clk     (clk),
        .rst     (rst),
        .start   (mul_start),
        .a       (req_r.a),
        .b       (req_r.b),
        .product (mul_product),
        .done    (mul_done)
    );

    int_to_float i_itof (
        .a (req_r.a),
        .f (itof_f)
    );

    always_comb begin
        case (req_r.op)
            OP_ADD, OP_SUB: begin
                unit_done   = add_done;
                unit_result = add_sum;
            end
            OP_MUL: begin
                unit_done   = mul_done;
                unit_result = mul_product;
            end
            default: begin
                unit_done   = 1'b1;
                unit_result = itof_f;
            end
        endcase
    end

    // A unit still shows done in the cycle its start pulse is high.
    assign finish = busy && !add_start && !mul_start && unit_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            add_start <= 1'b0;
            mul_start <= 1'b0;
            result    <= '0;
        end else begin
            add_start <= accept && (req.op == OP_ADD || req.op == OP_SUB);
            mul_start <= accept && (req.op == OP_MUL);
            if (accept) begin
                busy <= 1'b1;
            end else if (finish) begin
                busy   <= 1'b0;
                result <= unit_result;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_r <= req;
        end
    end

endmodule

// ==== fp_unit_properties.sv ====
`timescale 1ns/10ps

module fp_unit_properties (
    input logic           clk,
    input logic           rst,
    input logic           start,
    input logic           ready,
    input fp_pkg::float_t result
);

    // Idle right after reset.
    assert property (@(posedge clk) $fell(rst) |-> ready)
        else $error("ready is low in the cycle after reset");

    assert property (@(posedge clk) disable iff (rst) (start && ready) |=> !ready)
        else $error("ready did not fall after an accepted start");

    // A held result must not move while the unit stays idle.
    assert property (@(posedge clk) disable iff (rst) (ready && $past(ready)) |-> $stable(result))
        else $error("result changed while ready stayed high");

endmodule

bind fp_unit fp_unit_properties i_properties (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .ready  (ready),
    .result (result)
);

// ==== fp_unit_tb.sv ====
`timescale 1ns/10ps

module fp_unit_tb;
    import fp_pkg::*;

    localparam int NUM_TESTS       = 13;
    localparam int RESET_CYCLES    = 3;
    localparam int CYCLES_PER_TEST = 20;
    localparam int TIMEOUT_CYCLES  = NUM_TESTS * CYCLES_PER_TEST + RESET_CYCLES;

    typedef struct packed {
        fp_op_t op;
        float_t a;
        float_t b;
        float_t expected;
        logic   busy_start;
    } test_entry_t;

    logic        clk;
    logic        rst;
    logic        start;
    fp_request_t req;
    float_t      result;
    logic        ready;

    test_entry_t table_entries [NUM_TESTS];
    string       test_names [NUM_TESTS];
    int          entry_count;
    int          error_count;
    int          check_count;
    int          cycle_count;
    int          seed;
    int          gap;

    fp_unit i_dut (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .req    (req),
        .result (result),
        .ready  (ready)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles, the DUT never returned ready.",
                     cycle_count);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Stimulus table.
    ////////////////////////////////////////

    task automatic add_entry(input string name, input fp_op_t op, input float_t a,
                             input float_t b, input float_t expected,
                             input logic busy_start);
        test_entry_t entry;
        entry.op         = op;
        entry.a          = a;
        entry.b          = b;
        entry.expected   = expected;
        entry.busy_start = busy_start;
        test_names[entry_count]    = name;
        table_entries[entry_count] = entry;
        entry_count++;
    endtask

    task automatic load_table();
        add_entry("add_1p5_2p25", OP_ADD, 32'h3FC0_0000, 32'h4010_0000, 32'h4070_0000, 1'b0);
        add_entry("add_3_1", OP_ADD, 32'h4040_0000, 32'h3F80_0000, 32'h4080_0000, 1'b0);
        add_entry("sub_5_3", OP_SUB, 32'h40A0_0000, 32'h4040_0000, 32'h4000_0000, 1'b0);
        add_entry("sub_3_3", OP_SUB, 32'h4040_0000, 32'h4040_0000, 32'h0000_0000, 1'b0);
        add_entry("add_m6_2p5", OP_ADD, 32'hC0C0_0000, 32'h4020_0000, 32'hC060_0000, 1'b0);
        add_entry("mul_m2_3", OP_MUL, 32'hC000_0000, 32'h4040_0000, 32'hC0C0_0000, 1'b0);
        add_entry("mul_1p5_1p5", OP_MUL, 32'h3FC0_0000, 32'h3FC0_0000, 32'h4010_0000, 1'b0);
        add_entry("mul_0_7", OP_MUL, 32'h0000_0000, 32'h40E0_0000, 32'h0000_0000, 1'b0);
        add_entry("itof_100", OP_ITOF, 32'd100, 32'h0000_0000, 32'h42C8_0000, 1'b0);
        add_entry("itof_m1", OP_ITOF, 32'hFFFF_FFFF, 32'h0000_0000, 32'hBF80_0000, 1'b0);
        add_entry("itof_0", OP_ITOF, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 1'b0);
        add_entry("busy_start_ignored", OP_MUL, 32'hC000_0000, 32'h4040_0000, 32'hC0C0_0000,
                  1'b1);
        add_entry("after_ignored", OP_ADD, 32'h3F80_0000, 32'h3F80_0000, 32'h4000_0000, 1'b0);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic run_entry(input int index);
        test_entry_t entry;
        entry  = table_entries[index];
        req.op = entry.op;
        req.a  = entry.a;
        req.b  = entry.b;
        start  = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (entry.busy_start) begin
            // This request arrives while busy and must be dropped.
            check_value({test_names[index], "_ready_low"}, 32'd0, {31'd0, ready});
            req.op = OP_ITOF;
            req.a  = 32'd7;
            req.b  = 32'h0000_0000;
            start  = 1'b1;
            @(negedge clk);
            start = 1'b0;
        end
        while (!ready) begin
            @(negedge clk);
        end
        check_value(test_names[index], entry.expected, result);
    endtask

    ////////////////////////////////////////
    // Main sequence.
    ////////////////////////////////////////

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        start       = 1'b0;
        req         = '0;
        entry_count = 0;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        seed        = 32'h7a1e_a98d;
        load_table();

        repeat (RESET_CYCLES) begin
            @(negedge clk);
        end
        rst = 1'b0;

        for (int i = 0; i < NUM_TESTS; i++) begin
            // Short random idle gap between requests.
            gap = $random(seed) & 3;
            repeat (gap) begin
                @(negedge clk);
            end
            run_entry(i);
        end
        @(negedge clk);

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== int_to_float.sv ====
`timescale 1ns/10ps

module int_to_float (
    input  fp_pkg::float_t a,
    output fp_pkg::float_t f
);
    import fp_pkg::*;

    typedef logic [$clog2(FLOAT_BITS)-1:0] bit_pos_t;

    float_t     mag;
    float_t     norm;
    bit_pos_t   lead;
    fp_fields_t fields;

    assign mag = a[FLOAT_BITS-1] ? -a : a;

    // Leading one search.
    always_comb begin
        lead = '0;
        for (int i = 0; i < FLOAT_BITS; i++) begin
            if (mag[i]) begin
                lead = bit_pos_t'(i);
            end
        end
    end

    // Leading one moves to the top bit and drops out as the hidden one.
    assign norm = mag << (FLOAT_BITS - 1 - lead);

    always_comb begin
        fields.sign = a[FLOAT_BITS-1];
        fields.exp  = exponent_t'(EXP_BIAS + lead);
        fields.frac = norm[FLOAT_BITS-2 -: FRAC_BITS];
    end

    assign f = (mag == '0) ? '0 : fields;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the fp_unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module fp_unit_tb -Mdir obj_dir -f sim.f; then
    echo "Verilator build failed."
    exit 1
fi

output=$(./obj_dir/Vfp_unit_tb)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status."
    exit 1
fi

if grep -qx "TESTBENCH PASSED" <<< "$output"; then
    exit 0
fi
exit 1

// ==== sim.f ====
fp_pkg.sv
digit_multiplier.sv
fp_multiplier.sv
fp_adder.sv
int_to_float.sv
fp_unit.sv
fp_unit_properties.sv
fp_unit_tb.sv
